// ==== design/store_pkg.sv ====
package store_pkg;

	localparam int WORD_SIZE = 16;

	localparam int REG_NUM = 8;
	localparam int REG_INDEX = 3;

	localparam int RB_SIZE = 8;
	localparam int RB_INDEX = 3;

	localparam int STATION_NUM = 4;
	localparam int OPND_NUM = 3; // ri, rj, rk

	// memory credits
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_FULL = CREDIT_W'(CREDIT_MAX);

	localparam int OPCODE_WIDTH = 4;
	localparam int IMM_WIDTH = 6;

	localparam logic [OPCODE_WIDTH-1:0] OP_SWRR = 4'h9;
	localparam logic [OPCODE_WIDTH-1:0] OP_SWRI = 4'hA;

	// low field, register or immediate form
	typedef union packed {
		struct packed {
			logic [REG_INDEX-1:0] rk;
			logic [IMM_WIDTH-REG_INDEX-1:0] unused;
		} reg_form;
		logic [IMM_WIDTH-1:0] imm;
	} store_low_u;

	typedef struct packed {
		logic [OPCODE_WIDTH-1:0] op;
		logic [REG_INDEX-1:0] ri;
		logic [REG_INDEX-1:0] rj;
		store_low_u low;
	} store_inst_t;

	// one operand held in a station
	typedef struct packed {
		logic [WORD_SIZE-1:0] value;
		logic ready;
	} operand_t;

endpackage

// ==== design/issue_if.sv ====
`timescale 1ns/100ps

interface issue_if;

	// one-hot target station, zero when nothing issues
	logic [store_pkg::STATION_NUM-1:0] sel;
	logic [store_pkg::RB_INDEX-1:0] tag; // rob tag of the store

	// operand order is i, j, k
	logic [store_pkg::OPND_NUM-1:0][store_pkg::WORD_SIZE-1:0] val;
	logic [store_pkg::OPND_NUM-1:0] pend;
	logic [store_pkg::OPND_NUM-1:0][store_pkg::RB_INDEX-1:0] ptag;

	logic is_imm; // k operand is the immediate

	modport issue (
		output sel,
		output tag,
		output val,
		output pend,
		output ptag,
		output is_imm
	);

	modport station (
		input sel,
		input tag,
		input val,
		input pend,
		input ptag,
		input is_imm
	);

endinterface

// ==== design/reg_status.sv ====
`timescale 1ns/100ps

module reg_status (
	input logic clk,
	input logic reset,

	// operand reads for the issuing store
	input logic [store_pkg::OPND_NUM-1:0][store_pkg::REG_INDEX-1:0] read_reg,
	output logic [store_pkg::OPND_NUM-1:0][store_pkg::WORD_SIZE-1:0] read_val,
	output logic [store_pkg::OPND_NUM-1:0] read_pend,
	output logic [store_pkg::OPND_NUM-1:0][store_pkg::RB_INDEX-1:0] read_tag,

	input logic rename_valid,
	input logic [store_pkg::REG_INDEX-1:0] rename_reg,
	input logic [store_pkg::RB_INDEX-1:0] rename_tag,

	input logic cdb_valid,
	input logic [store_pkg::RB_INDEX-1:0] cdb_tag,
	input logic [store_pkg::WORD_SIZE-1:0] cdb_data
);

	logic [store_pkg::WORD_SIZE-1:0] value [store_pkg::REG_NUM];
	logic [store_pkg::REG_NUM-1:0] pend;
	logic [store_pkg::RB_INDEX-1:0] tag [store_pkg::REG_NUM];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < store_pkg::REG_NUM; r++) begin
				value[r] <= '0;
				pend[r] <= 1'b0;
				tag[r] <= '0;
			end
		end else begin
			// writeback to every register waiting on this tag
			for (int r = 0; r < store_pkg::REG_NUM; r++) begin
				if (cdb_valid && pend[r] && tag[r] == cdb_tag) begin
					value[r] <= cdb_data;
					pend[r] <= 1'b0;
				end
			end
			// later assignment, so a rename beats the writeback
			if (rename_valid) begin
				pend[rename_reg] <= 1'b1;
				tag[rename_reg] <= rename_tag;
			end
		end
	end

	// reads see the state before this cycle's rename
	always_comb begin
		for (int n = 0; n < store_pkg::OPND_NUM; n++) begin
			read_val[n] = value[read_reg[n]];
			read_pend[n] = pend[read_reg[n]];
			read_tag[n] = tag[read_reg[n]];
		end
	end

endmodule

// ==== design/store_station.sv ====
`timescale 1ns/100ps

module store_station #(
	parameter int SLOT = 0
) (
	input logic clk,
	input logic reset,

	issue_if.station iss,

	input logic cdb_valid,
	input logic [store_pkg::RB_INDEX-1:0] cdb_tag,
	input logic [store_pkg::WORD_SIZE-1:0] cdb_data,

	input logic free, // from commit
	output logic busy,
	output logic done,
	output logic [store_pkg::WORD_SIZE-1:0] addr,
	output logic [store_pkg::WORD_SIZE-1:0] data,
	output logic [store_pkg::RB_INDEX-1:0] tag
);

	store_pkg::operand_t vi;
	store_pkg::operand_t vj;
	store_pkg::operand_t vk;

	// producer tags of missing operands
	logic [store_pkg::RB_INDEX-1:0] qi;
	logic [store_pkg::RB_INDEX-1:0] qj;
	logic [store_pkg::RB_INDEX-1:0] qk;

	logic load;
	logic fire;

	assign load = iss.sel[SLOT];
	assign fire = busy & ~done & vi.ready & vj.ready & vk.ready;

	// take the bus value if this operand waits on it
	function automatic store_pkg::operand_t snoop(
		input store_pkg::operand_t op,
		input logic [store_pkg::RB_INDEX-1:0] q
	);
		snoop = op;
		if (!op.ready && cdb_valid && cdb_tag == q) begin
			snoop.value = cdb_data;
			snoop.ready = 1'b1;
		end
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			vi <= '0;
			vj <= '0;
			vk <= '0;
		end else if (load) begin
			busy <= 1'b1;
			done <= 1'b0;
			vi.value <= iss.val[0];
			vi.ready <= ~iss.pend[0];
			vj.value <= iss.val[1];
			vj.ready <= ~iss.pend[1];
			vk.value <= iss.val[2];
			vk.ready <= iss.is_imm | ~iss.pend[2]; // immediate never waits
		end else if (free) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (fire) begin
			done <= 1'b1; // held until commit frees us
		end else if (busy && !done) begin
			vi <= snoop(vi, qi);
			vj <= snoop(vj, qj);
			vk <= snoop(vk, qk);
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			qi <= iss.ptag[0];
			qj <= iss.ptag[1];
			qk <= iss.ptag[2];
			tag <= iss.tag;
		end
		if (fire) begin
			addr <= vj.value - vk.value;
			data <= vi.value;
		end
	end

endmodule

// ==== design/store_issue.sv ====
`timescale 1ns/100ps

module store_issue (
	input logic clk,
	input logic reset,

	input logic inst_valid,
	input store_pkg::store_inst_t inst,
	input logic [store_pkg::RB_INDEX-1:0] inst_tag,
	output logic inst_ready,

	input logic [store_pkg::STATION_NUM-1:0] busy,

	output logic [store_pkg::OPND_NUM-1:0][store_pkg::REG_INDEX-1:0] read_reg,
	input logic [store_pkg::OPND_NUM-1:0][store_pkg::WORD_SIZE-1:0] read_val,
	input logic [store_pkg::OPND_NUM-1:0] read_pend,
	input logic [store_pkg::OPND_NUM-1:0][store_pkg::RB_INDEX-1:0] read_tag,

	input logic cdb_valid,
	input logic [store_pkg::RB_INDEX-1:0] cdb_tag,
	input logic [store_pkg::WORD_SIZE-1:0] cdb_data,

	issue_if.issue iss
);

	logic [store_pkg::STATION_NUM-1:0] just_sel; // issued last cycle
	logic [store_pkg::STATION_NUM-1:0] avail;
	logic [store_pkg::STATION_NUM-1:0] pick;
	logic [store_pkg::STATION_NUM-1:0] sel;
	logic take;
	logic is_imm;
	logic [store_pkg::OPND_NUM-1:0] hit;
	logic [store_pkg::OPND_NUM-1:0][store_pkg::WORD_SIZE-1:0] op_val;
	logic [store_pkg::OPND_NUM-1:0] op_pend;
	logic [store_pkg::WORD_SIZE-1:0] imm_ext;

	assign avail = ~busy & ~just_sel;
	assign inst_ready = |avail;
	assign take = inst_valid & inst_ready;
	assign sel = take ? pick : '0;

	always_comb begin
		pick = '0;
		for (int s = store_pkg::STATION_NUM - 1; s >= 0; s--) begin
			if (avail[s]) begin
				pick = '0;
				pick[s] = 1'b1;
			end
		end
	end

	assign is_imm = inst.op == store_pkg::OP_SWRI;
	assign imm_ext = {{(store_pkg::WORD_SIZE - store_pkg::IMM_WIDTH){1'b0}}, inst.low.imm};

	assign read_reg[0] = inst.ri;
	assign read_reg[1] = inst.rj;
	assign read_reg[2] = inst.low.reg_form.rk;

	// same-cycle cdb bypass
	always_comb begin
		for (int n = 0; n < store_pkg::OPND_NUM; n++) begin
			hit[n] = cdb_valid & read_pend[n] & (cdb_tag == read_tag[n]);
			op_val[n] = hit[n] ? cdb_data : read_val[n];
			op_pend[n] = read_pend[n] & ~hit[n];
		end
	end

	assign iss.sel = sel;
	assign iss.tag = inst_tag;
	assign iss.val[0] = op_val[0];
	assign iss.val[1] = op_val[1];
	assign iss.val[2] = is_imm ? imm_ext : op_val[2];
	assign iss.pend = {op_pend[2] & ~is_imm, op_pend[1:0]};
	assign iss.ptag = read_tag;
	assign iss.is_imm = is_imm;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			just_sel <= '0;
		else
			just_sel <= sel;
	end

endmodule

// ==== design/store_commit.sv ====
`timescale 1ns/100ps

module store_commit (
	input logic clk,
	input logic reset,

	input logic [store_pkg::STATION_NUM-1:0] done,
	input logic [store_pkg::STATION_NUM-1:0][store_pkg::WORD_SIZE-1:0] addr,
	input logic [store_pkg::STATION_NUM-1:0][store_pkg::WORD_SIZE-1:0] data,
	input logic [store_pkg::STATION_NUM-1:0][store_pkg::RB_INDEX-1:0] tag,
	output logic [store_pkg::STATION_NUM-1:0] free,

	input logic mem_credit,
	output logic mem_valid,
	output logic [store_pkg::WORD_SIZE-1:0] mem_addr,
	output logic [store_pkg::WORD_SIZE-1:0] mem_data,
	output logic [store_pkg::RB_INDEX-1:0] mem_tag
);

	logic [store_pkg::CREDIT_W-1:0] credit;
	logic [store_pkg::CREDIT_W-1:0] credit_up;
	logic [store_pkg::CREDIT_W-1:0] credit_dn;
	logic [store_pkg::STATION_NUM-1:0] pick;
	logic send;
	logic [store_pkg::WORD_SIZE-1:0] win_addr;
	logic [store_pkg::WORD_SIZE-1:0] win_data;
	logic [store_pkg::RB_INDEX-1:0] win_tag;

	// fixed priority, lowest index first
	always_comb begin
		pick = '0;
		for (int s = store_pkg::STATION_NUM - 1; s >= 0; s--) begin
			if (done[s]) begin
				pick = '0;
				pick[s] = 1'b1;
			end
		end
	end

	assign free = (credit != '0) ? pick : '0;
	assign send = |free;

	always_comb begin
		win_addr = '0;
		win_data = '0;
		win_tag = '0;
		for (int s = 0; s < store_pkg::STATION_NUM; s++) begin
			if (free[s]) begin
				win_addr = addr[s];
				win_data = data[s];
				win_tag = tag[s];
			end
		end
	end

	assign credit_up = {{(store_pkg::CREDIT_W - 1){1'b0}}, mem_credit};
	assign credit_dn = {{(store_pkg::CREDIT_W - 1){1'b0}}, send};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			credit <= store_pkg::CREDIT_FULL;
			mem_valid <= 1'b0;
		end else begin
			credit <= credit + credit_up - credit_dn;
			mem_valid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			mem_addr <= win_addr;
			mem_data <= win_data;
			mem_tag <= win_tag;
		end
	end

endmodule

// ==== design/store_unit.sv ====
`timescale 1ns/100ps

module store_unit (
	input logic clk,
	input logic reset,

	input logic inst_valid,
	input store_pkg::store_inst_t inst,
	input logic [store_pkg::RB_INDEX-1:0] inst_tag,
	output logic inst_ready,

	input logic rename_valid,
	input logic [store_pkg::REG_INDEX-1:0] rename_reg,
	input logic [store_pkg::RB_INDEX-1:0] rename_tag,

	input logic cdb_valid,
	input logic [store_pkg::RB_INDEX-1:0] cdb_tag,
	input logic [store_pkg::WORD_SIZE-1:0] cdb_data,

	output logic mem_valid,
	output logic [store_pkg::WORD_SIZE-1:0] mem_addr,
	output logic [store_pkg::WORD_SIZE-1:0] mem_data,
	output logic [store_pkg::RB_INDEX-1:0] mem_tag,
	input logic mem_credit
);

	logic [store_pkg::STATION_NUM-1:0] busy;
	logic [store_pkg::STATION_NUM-1:0] done;
	logic [store_pkg::STATION_NUM-1:0] free;
	logic [store_pkg::STATION_NUM-1:0][store_pkg::WORD_SIZE-1:0] st_addr;
	logic [store_pkg::STATION_NUM-1:0][store_pkg::WORD_SIZE-1:0] st_data;
	logic [store_pkg::STATION_NUM-1:0][store_pkg::RB_INDEX-1:0] st_tag;

	logic [store_pkg::OPND_NUM-1:0][store_pkg::REG_INDEX-1:0] read_reg;
	logic [store_pkg::OPND_NUM-1:0][store_pkg::WORD_SIZE-1:0] read_val;
	logic [store_pkg::OPND_NUM-1:0] read_pend;
	logic [store_pkg::OPND_NUM-1:0][store_pkg::RB_INDEX-1:0] read_tag;

	issue_if iss_bus ();

	store_issue u_issue (
		.clk(clk),
		.reset(reset),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_tag(inst_tag),
		.inst_ready(inst_ready),
		.busy(busy),
		.read_reg(read_reg),
		.read_val(read_val),
		.read_pend(read_pend),
		.read_tag(read_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.iss(iss_bus.issue)
	);

	reg_status u_regs (
		.clk(clk),
		.reset(reset),
		.read_reg(read_reg),
		.read_val(read_val),
		.read_pend(read_pend),
		.read_tag(read_tag),
		.rename_valid(rename_valid),
		.rename_reg(rename_reg),
		.rename_tag(rename_tag),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data)
	);

	for (genvar i = 0; i < store_pkg::STATION_NUM; i++) begin : g_station
		store_station #(
			.SLOT(i)
		) u_station (
			.clk(clk),
			.reset(reset),
			.iss(iss_bus.station),
			.cdb_valid(cdb_valid),
			.cdb_tag(cdb_tag),
			.cdb_data(cdb_data),
			.free(free[i]),
			.busy(busy[i]),
			.done(done[i]),
			.addr(st_addr[i]),
			.data(st_data[i]),
			.tag(st_tag[i])
		);
	end

	store_commit u_commit (
		.clk(clk),
		.reset(reset),
		.done(done),
		.addr(st_addr),
		.data(st_data),
		.tag(st_tag),
		.free(free),
		.mem_credit(mem_credit),
		.mem_valid(mem_valid),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_tag(mem_tag)
	);

endmodule

// ==== bench/store_properties.sv ====
`timescale 1ns/100ps

module store_properties (
	input logic clk,
	input logic reset,
	input logic inst_ready,
	input logic mem_valid,
	input logic mem_credit
);

	int credit; // writes memory can still take

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			credit <= store_pkg::CREDIT_MAX;
		else
			credit <= credit + int'(mem_credit) - int'(mem_valid);
	end

	reset_idle: assert property (@(posedge clk) $fell(reset) |-> (!mem_valid && inst_ready))
		else $error("unit not idle after reset");

	credit_used: assert property (@(posedge clk) disable iff (reset) mem_valid |-> credit > 0)
		else $error("mem write sent with no credit left");

	credit_bound: assert property (@(posedge clk) disable iff (reset)
		credit <= store_pkg::CREDIT_MAX)
		else $error("more credits returned than writes sent");

endmodule

// ==== bench/store_checker.sv ====
`timescale 1ns/100ps

module store_checker (
	input logic clk,
	input logic reset,
	input logic inst_valid,
	input store_pkg::store_inst_t inst,
	input logic [store_pkg::RB_INDEX-1:0] inst_tag,
	input logic inst_ready,
	input logic rename_valid,
	input logic [store_pkg::REG_INDEX-1:0] rename_reg,
	input logic [store_pkg::RB_INDEX-1:0] rename_tag,
	input logic cdb_valid,
	input logic [store_pkg::RB_INDEX-1:0] cdb_tag,
	input logic [store_pkg::WORD_SIZE-1:0] cdb_data,
	input logic mem_valid,
	input logic [store_pkg::WORD_SIZE-1:0] mem_addr,
	input logic [store_pkg::WORD_SIZE-1:0] mem_data,
	input logic [store_pkg::RB_INDEX-1:0] mem_tag,
	input logic mem_credit,
	output int errors,
	output int due
);

	logic [store_pkg::WORD_SIZE-1:0] reg_val [store_pkg::REG_NUM];
	logic reg_pend [store_pkg::REG_NUM];
	logic [store_pkg::RB_INDEX-1:0] reg_tag [store_pkg::REG_NUM];

	// expected operands per store tag, order i j k
	logic [store_pkg::WORD_SIZE-1:0] op_val [store_pkg::RB_SIZE][3];
	logic op_pend [store_pkg::RB_SIZE][3];
	logic [store_pkg::RB_INDEX-1:0] op_tag [store_pkg::RB_SIZE][3];
	logic live [store_pkg::RB_SIZE];
	int outstanding;

	always @(posedge clk or posedge reset) begin : model
		logic [store_pkg::REG_INDEX-1:0] src [3];
		logic [store_pkg::WORD_SIZE-1:0] exp_addr;
		if (reset) begin
			errors = 0;
			due = 0;
			outstanding = 0;
			for (int r = 0; r < store_pkg::REG_NUM; r++) begin
				reg_val[r] = '0;
				reg_pend[r] = 1'b0;
				reg_tag[r] = '0;
			end
			for (int t = 0; t < store_pkg::RB_SIZE; t++)
				live[t] = 1'b0;
		end else begin
			if (mem_valid) begin
				if (!live[mem_tag]) begin
					errors++;
					$display("mem write with unknown or duplicate tag %0d", mem_tag);
				end else if (op_pend[mem_tag][0] | op_pend[mem_tag][1] | op_pend[mem_tag][2]) begin
					errors++;
					$display("tag %0d written before its operands were broadcast", mem_tag);
				end else begin
					exp_addr = op_val[mem_tag][1] - op_val[mem_tag][2]; // rj - rk or rj - imm
					if (mem_addr !== exp_addr) begin
						errors++;
						$display("[FAIL] mem_addr tag %0d: got %h, expected %h",
							mem_tag, mem_addr, exp_addr);
					end
					if (mem_data !== op_val[mem_tag][0]) begin
						errors++;
						$display("[FAIL] mem_data tag %0d: got %h, expected %h",
							mem_tag, mem_data, op_val[mem_tag][0]);
					end
				end
				if (live[mem_tag]) begin
					live[mem_tag] = 1'b0;
					due--;
				end
				outstanding++;
			end
			if (mem_credit)
				outstanding--;
			if (outstanding > store_pkg::CREDIT_MAX) begin
				errors++;
				$display("%0d writes outstanding, more than the credit limit", outstanding);
			end

			// waiting stores pick up the broadcast
			for (int t = 0; t < store_pkg::RB_SIZE; t++)
				for (int n = 0; n < 3; n++)
					if (live[t] && op_pend[t][n] && cdb_valid && op_tag[t][n] == cdb_tag) begin
						op_val[t][n] = cdb_data;
						op_pend[t][n] = 1'b0;
					end

			if (inst_valid && inst_ready) begin
				if (live[inst_tag]) begin
					errors++;
					$display("tag %0d issued again while still in flight", inst_tag);
				end
				src[0] = inst.ri;
				src[1] = inst.rj;
				src[2] = inst.low.reg_form.rk;
				for (int n = 0; n < 3; n++) begin
					op_val[inst_tag][n] = reg_val[src[n]];
					op_pend[inst_tag][n] = reg_pend[src[n]];
					op_tag[inst_tag][n] = reg_tag[src[n]];
					if (reg_pend[src[n]] && cdb_valid && reg_tag[src[n]] == cdb_tag) begin
						op_val[inst_tag][n] = cdb_data; // same-cycle bypass
						op_pend[inst_tag][n] = 1'b0;
					end
				end
				if (inst.op == store_pkg::OP_SWRI) begin
					op_val[inst_tag][2] = store_pkg::WORD_SIZE'(inst.low.imm);
					op_pend[inst_tag][2] = 1'b0;
				end
				live[inst_tag] = 1'b1;
				due++;
			end

			for (int r = 0; r < store_pkg::REG_NUM; r++)
				if (cdb_valid && reg_pend[r] && reg_tag[r] == cdb_tag) begin
					reg_val[r] = cdb_data;
					reg_pend[r] = 1'b0;
				end
			if (rename_valid) begin // rename beats writeback
				reg_pend[rename_reg] = 1'b1;
				reg_tag[rename_reg] = rename_tag;
			end
		end
	end

endmodule

// ==== bench/store_unit_tb.sv ====
`timescale 1ns/100ps

module store_unit_tb;

	localparam int STORE_COUNT = 400;
	localparam int CYCLE_LIMIT = STORE_COUNT * 30;
	localparam int FILL_STORES = 2 * store_pkg::STATION_NUM; // four go out on credit
	localparam int WAIT_LIMIT = 60;

	logic clk;
	logic reset;
	logic inst_valid;
	store_pkg::store_inst_t inst;
	logic [store_pkg::RB_INDEX-1:0] inst_tag;
	logic inst_ready;
	logic rename_valid;
	logic [store_pkg::REG_INDEX-1:0] rename_reg;
	logic [store_pkg::RB_INDEX-1:0] rename_tag;
	logic cdb_valid;
	logic [store_pkg::RB_INDEX-1:0] cdb_tag;
	logic [store_pkg::WORD_SIZE-1:0] cdb_data;
	logic mem_valid;
	logic [store_pkg::WORD_SIZE-1:0] mem_addr;
	logic [store_pkg::WORD_SIZE-1:0] mem_data;
	logic [store_pkg::RB_INDEX-1:0] mem_tag;
	logic mem_credit;

	int check_errors;
	int due;
	int errors = 0;
	int written = 0;
	int ticks = 0;

	store_unit dut (.*);

	store_checker u_checker (.*, .errors(check_errors), .due(due));

	bind store_unit store_properties u_props (
		.clk(clk),
		.reset(reset),
		.inst_ready(inst_ready),
		.mem_valid(mem_valid),
		.mem_credit(mem_credit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		ticks++;
		if (ticks >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d stores written", ticks, written);
			$display("errors: %0d", errors + check_errors + 1);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin : stimulus
		int cycle;
		int issued;
		int fill_state; // 0 filling, 1 credits released, 2 done
		int fill_wait;
		int pick;
		int r;
		logic hold_credit;
		logic took;
		logic tag_busy [4];
		logic [1:0] next_tag;
		logic [3:0] live_tags; // rename tags 4..7 with a pending register
		logic reg_pend [store_pkg::REG_NUM];
		logic [store_pkg::RB_INDEX-1:0] reg_tag [store_pkg::REG_NUM];
		int credit_due [$];

		void'($urandom(32'h1c74));
		cycle = 0;
		issued = 0;
		fill_state = 0;
		fill_wait = 0;
		hold_credit = 1'b1;
		next_tag = '0;
		for (int t = 0; t < 4; t++)
			tag_busy[t] = 1'b0;
		for (int g = 0; g < store_pkg::REG_NUM; g++) begin
			reg_pend[g] = 1'b0;
			reg_tag[g] = '0;
		end
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		inst_tag = '0;
		rename_valid = 1'b0;
		rename_reg = '0;
		rename_tag = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		mem_credit = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		while (written < STORE_COUNT) begin
			@(posedge clk);
			cycle++;
			took = inst_valid & inst_ready;
			if (took) begin
				tag_busy[inst_tag[1:0]] = 1'b1;
				issued++;
			end
			if (mem_valid) begin
				tag_busy[mem_tag[1:0]] = 1'b0;
				written++;
				credit_due.push_back(cycle + int'($urandom_range(6)));
			end
			for (int g = 0; g < store_pkg::REG_NUM; g++)
				if (cdb_valid && reg_pend[g] && reg_tag[g] == cdb_tag)
					reg_pend[g] = 1'b0;
			if (rename_valid) begin
				reg_pend[rename_reg] = 1'b1;
				reg_tag[rename_reg] = rename_tag;
			end

			// back-pressure with credits withheld
			if (fill_state == 0 && issued == FILL_STORES && !inst_ready) begin
				if (written != store_pkg::STATION_NUM) begin
					errors++;
					$display("inst_ready fell with %0d stores written, expected 4", written);
				end
				fill_state = 1;
				fill_wait = 0;
				hold_credit = 1'b0;
			end else if (fill_state == 1 && inst_ready) begin
				fill_state = 2;
			end else if (fill_state < 2 && issued >= FILL_STORES) begin
				fill_wait++;
				if (fill_wait > WAIT_LIMIT) begin
					errors++;
					$display("inst_ready stuck in back-pressure phase %0d", fill_state);
					fill_state = 2;
					hold_credit = 1'b0;
				end
			end

			@(negedge clk);
			mem_credit = 1'b0;
			pick = -1;
			foreach (credit_due[i])
				if (pick < 0 && credit_due[i] <= cycle)
					pick = i;
			if (!hold_credit && pick >= 0) begin
				credit_due.delete(pick);
				mem_credit = 1'b1;
			end

			live_tags = '0;
			for (int g = 0; g < store_pkg::REG_NUM; g++)
				if (reg_pend[g])
					live_tags[reg_tag[g][1:0]] = 1'b1;
			cdb_valid = 1'b0;
			if (live_tags != '0 && $urandom_range(2) == 0) begin
				do
					pick = int'($urandom_range(3));
				while (!live_tags[pick]);
				cdb_valid = 1'b1;
				cdb_tag = 3'(4 + pick);
				cdb_data = 16'($urandom());
			end

			// only rename a register nobody can still be waiting on
			rename_valid = 1'b0;
			r = int'($urandom_range(7));
			if ($urandom_range(3) == 0 && (!reg_pend[r] || (cdb_valid && reg_tag[r] == cdb_tag))) begin
				rename_valid = 1'b1;
				rename_reg = 3'(r);
				rename_tag = 3'(4 + int'($urandom_range(3)));
			end

			if (!inst_valid || took) begin
				inst_valid = 1'b0;
				if (issued < ((fill_state == 0) ? FILL_STORES : STORE_COUNT)
						&& !tag_busy[next_tag] && $urandom_range(3) != 0) begin
					inst_valid = 1'b1;
					inst.op = ($urandom_range(1) != 0) ? store_pkg::OP_SWRI : store_pkg::OP_SWRR;
					inst.ri = 3'($urandom_range(7));
					inst.rj = 3'($urandom_range(7));
					inst.low.imm = 6'($urandom_range(63));
					inst_tag = {1'b0, next_tag};
					next_tag = next_tag + 2'd1;
				end
			end
		end

		// inputs idle while the last writes drain
		inst_valid = 1'b0;
		rename_valid = 1'b0;
		cdb_valid = 1'b0;
		mem_credit = 1'b0;
		repeat (4) @(posedge clk);
		if (due != 0) begin
			errors++;
			$display("%0d stores never reached mem", due);
		end
		if (fill_state != 2) begin
			errors++;
			$display("back-pressure phase never finished");
		end
		$display("errors: %0d", errors + check_errors);
		if (errors + check_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== store_unit.f ====
design/store_pkg.sv
design/issue_if.sv
design/reg_status.sv
design/store_station.sv
design/store_issue.sv
design/store_commit.sv
design/store_unit.sv
bench/store_properties.sv
bench/store_checker.sv
bench/store_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the store unit testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module store_unit_tb \
	-f store_unit.f -o store_sim > build.log 2>&1 \
	&& ./obj_dir/store_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "\*\*\* FAILED \*\*\*" sim.log && { echo "simulation failed"; exit 1; }
grep -q "\*\*\* PASSED \*\*\*" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0
